// ==== logic/fetch_pkg.sv ====
////////////////////////////////////////
// Fetch stage widths and types
// Group is four aligned words, 16 bytes
// Word 0 sits in the low 32 bits
////////////////////////////////////////

package fetch_pkg;

    localparam int GROUP_WORDS = 4;    // Fixed, address math relies on it
    localparam int WORD_W      = 32;

    typedef logic [WORD_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;

    // Slot i in bits [32*i +: 32]
    typedef word_t [GROUP_WORDS-1:0] group_data_t;

    typedef logic [GROUP_WORDS-1:0]         slot_mask_t;
    typedef logic [$clog2(GROUP_WORDS)-1:0] slot_idx_t;

endpackage

// ==== logic/bpred_pkg.sv ====
////////////////////////////////////////
// Branch target buffer types
// Tag width fits 16 entries; smaller tables
// drop the top address bits from the tag
////////////////////////////////////////

package bpred_pkg;

    import fetch_pkg::*;

    localparam int BTB_TAG_W = 26;

    typedef logic [BTB_TAG_W-1:0] btb_tag_t;

    typedef struct packed {
        logic     valid;
        btb_tag_t tag;
        logic     take;
        addr_t    target;
    } btb_entry_t;

    typedef struct packed {
        logic       take;      // Taken branch found in the group
        addr_t      target;
        slot_mask_t enable;    // Truncated after the taken slot
    } btb_result_t;

endpackage

// ==== logic/fetch_ifs.sv ====
////////////////////////////////////////
// Internal fetch stage interfaces
// Lookup has no handshake, result is
// valid in the same cycle as the PC
////////////////////////////////////////
`timescale 1ns/1ps

interface btb_lookup_if import fetch_pkg::*; ();

    addr_t      pc;
    logic       take;
    addr_t      target;
    slot_mask_t enable;

    modport requester (
        output pc,
        input  take,
        input  target,
        input  enable
    );

    modport predictor (
        input  pc,
        output take,
        output target,
        output enable
    );

endinterface

// Tag moves on valid and ready, same edge as the memory request
interface fetch_tag_if import fetch_pkg::*; ();

    logic       valid;
    logic       ready;
    addr_t      pc;
    slot_mask_t enable;
    logic       pred_take;
    addr_t      pred_target;

    modport issuer (
        output valid,
        input  ready,
        output pc,
        output enable,
        output pred_take,
        output pred_target
    );

    modport tracker (
        input  valid,
        output ready,
        input  pc,
        input  enable,
        input  pred_take,
        input  pred_target
    );

endinterface

// ==== logic/pc_register.sv ====
////////////////////////////////////////
// Fetch PC and memory request issue
// No request in a redirect cycle
// Redirect wins over the predicted target
////////////////////////////////////////
`timescale 1ns/1ps

module pc_register import fetch_pkg::*; #(
    parameter addr_t RESET_PC = 32'h0000_0000
) (
    input  logic  clk,
    input  logic  arst_n_i,

    input  logic  mem_req_ready_i,
    output logic  mem_req_valid_o,
    output addr_t mem_req_addr_o,

    input  logic  redirect_valid_i,
    input  addr_t redirect_pc_i,

    btb_lookup_if.requester lookup,
    fetch_tag_if.issuer     tag
);

    addr_t pc_q;
    addr_t pc_d;
    addr_t aligned_pc;
    addr_t seq_pc;
    logic  run_q;       // Low until the first edge after reset
    logic  req_fire;

    ////////////////////////////////////////
    // Request side
    ////////////////////////////////////////

    assign aligned_pc = {pc_q[31:4], 4'b0000};
    assign seq_pc     = aligned_pc + addr_t'(GROUP_WORDS * 4);

    assign mem_req_valid_o = run_q & tag.ready & ~redirect_valid_i;
    assign mem_req_addr_o  = aligned_pc;
    assign req_fire        = mem_req_valid_o & mem_req_ready_i;

    // Tracker takes the tag exactly when memory takes the request
    assign tag.valid       = run_q & ~redirect_valid_i & mem_req_ready_i;
    assign tag.pc          = pc_q;
    assign tag.enable      = lookup.enable;
    assign tag.pred_take   = lookup.take;
    assign tag.pred_target = lookup.target;

    assign lookup.pc = pc_q;

    ////////////////////////////////////////
    // Next PC
    ////////////////////////////////////////

    always_comb begin
        pc_d = pc_q;
        if (redirect_valid_i) begin
            pc_d = redirect_pc_i;
        end else if (req_fire) begin
            pc_d = lookup.take ? lookup.target : seq_pc;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q  <= RESET_PC;
            run_q <= 1'b0;
        end else begin
            pc_q  <= pc_d;
            run_q <= 1'b1;
        end
    end

endmodule

// ==== logic/branch_target_buffer.sv ====
////////////////////////////////////////
// Direct-mapped branch target buffer
// BTB_ENTRIES power of two, at least 4
// Lookup is combinational, update lands
// at the edge and shows the next cycle
////////////////////////////////////////
`timescale 1ns/1ps

module branch_target_buffer import fetch_pkg::*, bpred_pkg::*; #(
    parameter int BTB_ENTRIES = 16
) (
    input  logic  clk,
    input  logic  arst_n_i,

    input  logic  bp_update_valid_i,
    input  addr_t bp_update_pc_i,
    input  logic  bp_update_take_i,
    input  addr_t bp_update_target_i,

    btb_lookup_if.predictor lookup
);

    localparam int IDX_W = $clog2(BTB_ENTRIES);

    typedef logic [IDX_W-1:0] btb_idx_t;

    btb_entry_t  table_q [BTB_ENTRIES];
    btb_entry_t  upd_entry;
    addr_t       base_pc;
    addr_t       slot_pc    [GROUP_WORDS];
    btb_entry_t  slot_entry [GROUP_WORDS];
    slot_idx_t   start_slot;
    slot_mask_t  start_mask;
    slot_mask_t  slot_hit;
    btb_result_t result;

    function automatic btb_idx_t btb_index(addr_t a);
        return a[IDX_W+1:2];
    endfunction

    function automatic btb_tag_t btb_tag(addr_t a);
        return btb_tag_t'(a >> (IDX_W + 2));
    endfunction

    ////////////////////////////////////////
    // Four slot lookup
    ////////////////////////////////////////

    assign base_pc    = {lookup.pc[31:4], 4'b0000};
    assign start_slot = lookup.pc[3:2];
    assign start_mask = slot_mask_t'({GROUP_WORDS{1'b1}} << start_slot);

    for (genvar i = 0; i < GROUP_WORDS; i++) begin : g_slot
        assign slot_pc[i]    = base_pc + addr_t'(4 * i);
        assign slot_entry[i] = table_q[btb_index(slot_pc[i])];
        assign slot_hit[i]   = start_mask[i] & slot_entry[i].valid & slot_entry[i].take
                             & (slot_entry[i].tag == btb_tag(slot_pc[i]));
    end

    // Lowest hitting slot wins
    always_comb begin
        result.take   = 1'b0;
        result.target = '0;
        result.enable = start_mask;
        for (int i = GROUP_WORDS - 1; i >= 0; i--) begin
            if (slot_hit[i]) begin
                result.take   = 1'b1;
                result.target = slot_entry[i].target;
                result.enable = start_mask & slot_mask_t'((2 << i) - 1);
            end
        end
    end

    assign lookup.take   = result.take;
    assign lookup.target = result.target;
    assign lookup.enable = result.enable;

    ////////////////////////////////////////
    // Backend update
    ////////////////////////////////////////

    always_comb begin
        upd_entry.valid  = 1'b1;
        upd_entry.tag    = btb_tag(bp_update_pc_i);
        upd_entry.take   = bp_update_take_i;    // Not taken clears the prediction
        upd_entry.target = bp_update_target_i;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            table_q <= '{default: '0};
        end else if (bp_update_valid_i) begin
            table_q[btb_index(bp_update_pc_i)] <= upd_entry;
        end
    end

endmodule

// ==== logic/fetch_trace.sv ====
////////////////////////////////////////
// In-flight request tracking and output
// Responses come in request order, never
// without an outstanding request
// Cancelled responses are dropped
////////////////////////////////////////
`timescale 1ns/1ps

module fetch_trace import fetch_pkg::*; #(
    parameter int MAX_INFLIGHT = 2
) (
    input  logic        clk,
    input  logic        arst_n_i,

    input  logic        mem_rsp_valid_i,
    input  group_data_t mem_rsp_data_i,
    input  logic        redirect_valid_i,

    input  logic        grp_ready_i,
    output logic        grp_valid_o,
    output addr_t       grp_pc_o,
    output slot_mask_t  grp_enable_o,
    output group_data_t grp_inst_o,
    output logic        grp_pred_take_o,
    output addr_t       grp_pred_target_o,

    fetch_tag_if.tracker tag
);

    localparam int PTR_W = (MAX_INFLIGHT > 1) ? $clog2(MAX_INFLIGHT) : 1;
    localparam int CNT_W = $clog2(MAX_INFLIGHT + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;
    typedef logic [CNT_W:0]   occ_t;

    typedef struct packed {
        addr_t      pc;
        slot_mask_t enable;
        logic       pred_take;
        addr_t      pred_target;
    } tag_meta_t;

    tag_meta_t   meta_q [MAX_INFLIGHT];
    group_data_t data_q [MAX_INFLIGHT];    // Holds a response while the output is busy
    logic [MAX_INFLIGHT-1:0] cancel_q;
    logic [MAX_INFLIGHT-1:0] filled_q;
    ptr_t        wr_ptr_q;
    ptr_t        rsp_ptr_q;
    ptr_t        rd_ptr_q;
    cnt_t        count_q;
    logic        out_valid_q;
    tag_meta_t   out_meta_q;
    group_data_t out_data_q;

    tag_meta_t   push_meta;
    group_data_t head_data;
    occ_t        occupancy;
    logic        push;
    logic        head_avail;
    logic        head_drop;
    logic        head_load;
    logic        pop;

    function automatic ptr_t ptr_inc(ptr_t p);
        return (p == ptr_t'(MAX_INFLIGHT - 1)) ? '0 : p + ptr_t'(1);
    endfunction

    ////////////////////////////////////////
    // Tag queue
    ////////////////////////////////////////

    assign push = tag.valid & tag.ready;

    always_comb begin
        push_meta.pc          = tag.pc;
        push_meta.enable      = tag.enable;
        push_meta.pred_take   = tag.pred_take;
        push_meta.pred_target = tag.pred_target;
    end

    // Head data bypasses storage when its response arrives now
    assign head_avail = (count_q != '0) & (filled_q[rd_ptr_q] | mem_rsp_valid_i);
    assign head_data  = filled_q[rd_ptr_q] ? data_q[rd_ptr_q] : mem_rsp_data_i;
    assign head_drop  = head_avail & (cancel_q[rd_ptr_q] | redirect_valid_i);
    assign head_load  = head_avail & ~head_drop & (~out_valid_q | grp_ready_i);
    assign pop        = head_drop | head_load;

    assign occupancy = occ_t'(count_q) + occ_t'(out_valid_q);
    assign tag.ready = occupancy < occ_t'(MAX_INFLIGHT);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q  <= '0;
            rsp_ptr_q <= '0;
            rd_ptr_q  <= '0;
            count_q   <= '0;
            cancel_q  <= '0;
            filled_q  <= '0;
        end else begin
            if (push)
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (mem_rsp_valid_i)
                rsp_ptr_q <= ptr_inc(rsp_ptr_q);
            if (pop)
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            count_q <= count_q + cnt_t'(push) - cnt_t'(pop);

            if (mem_rsp_valid_i)
                filled_q[rsp_ptr_q] <= 1'b1;
            if (redirect_valid_i)
                cancel_q <= '1;          // Everything outstanding is stale
            if (push) begin
                filled_q[wr_ptr_q] <= 1'b0;
                cancel_q[wr_ptr_q] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            meta_q[wr_ptr_q] <= push_meta;
        if (mem_rsp_valid_i)
            data_q[rsp_ptr_q] <= mem_rsp_data_i;
    end

    ////////////////////////////////////////
    // Output register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_valid_q <= 1'b0;
        end else if (redirect_valid_i) begin
            out_valid_q <= 1'b0;
        end else if (head_load) begin
            out_valid_q <= 1'b1;
        end else if (grp_ready_i) begin
            out_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (head_load) begin
            out_meta_q <= meta_q[rd_ptr_q];
            out_data_q <= head_data;
        end
    end

    assign grp_valid_o       = out_valid_q;
    assign grp_pc_o          = out_meta_q.pc;
    assign grp_enable_o      = out_meta_q.enable;
    assign grp_inst_o        = out_data_q;
    assign grp_pred_take_o   = out_meta_q.pred_take;
    assign grp_pred_target_o = out_meta_q.pred_target;

endmodule

// ==== logic/fetch_top.sv ====
////////////////////////////////////////
// Instruction fetch stage, top level
// Addresses go to memory untranslated
// At most MAX_INFLIGHT groups held
////////////////////////////////////////
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
    parameter addr_t RESET_PC     = 32'h0000_1000,
    parameter int    BTB_ENTRIES  = 16,
    parameter int    MAX_INFLIGHT = 2
) (
    input  logic        clk,
    input  logic        arst_n_i,

    // Memory request
    output logic        mem_req_valid_o,
    input  logic        mem_req_ready_i,
    output addr_t       mem_req_addr_o,

    // Memory response, in order
    input  logic        mem_rsp_valid_i,
    input  group_data_t mem_rsp_data_i,

    // Fetch group to the instruction queue
    output logic        grp_valid_o,
    input  logic        grp_ready_i,
    output addr_t       grp_pc_o,
    output slot_mask_t  grp_enable_o,
    output group_data_t grp_inst_o,
    output logic        grp_pred_take_o,
    output addr_t       grp_pred_target_o,

    // Backend
    input  logic        redirect_valid_i,
    input  addr_t       redirect_pc_i,
    input  logic        bp_update_valid_i,
    input  addr_t       bp_update_pc_i,
    input  logic        bp_update_take_i,
    input  addr_t       bp_update_target_i
);

    btb_lookup_if u_lookup_if ();
    fetch_tag_if  u_tag_if ();

    pc_register #(
        .RESET_PC (RESET_PC)
    ) u_pc_register (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_addr_o   (mem_req_addr_o),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .lookup           (u_lookup_if),
        .tag              (u_tag_if)
    );

    branch_target_buffer #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) u_branch_target_buffer (
        .clk                (clk),
        .arst_n_i           (arst_n_i),
        .bp_update_valid_i  (bp_update_valid_i),
        .bp_update_pc_i     (bp_update_pc_i),
        .bp_update_take_i   (bp_update_take_i),
        .bp_update_target_i (bp_update_target_i),
        .lookup             (u_lookup_if)
    );

    fetch_trace #(
        .MAX_INFLIGHT (MAX_INFLIGHT)
    ) u_fetch_trace (
        .clk               (clk),
        .arst_n_i          (arst_n_i),
        .mem_rsp_valid_i   (mem_rsp_valid_i),
        .mem_rsp_data_i    (mem_rsp_data_i),
        .redirect_valid_i  (redirect_valid_i),
        .grp_ready_i       (grp_ready_i),
        .grp_valid_o       (grp_valid_o),
        .grp_pc_o          (grp_pc_o),
        .grp_enable_o      (grp_enable_o),
        .grp_inst_o        (grp_inst_o),
        .grp_pred_take_o   (grp_pred_take_o),
        .grp_pred_target_o (grp_pred_target_o),
        .tag               (u_tag_if)
    );

endmodule

// ==== testbench/fetch_model.svh ====
////////////////////////////////////////
// Reference model for the fetch testbench
// Included inside fetch_tb, needs its
// BTB_ENTRIES and the fetch_pkg types
// Update PCs must be word aligned
////////////////////////////////////////
`ifndef FETCH_MODEL_SVH
`define FETCH_MODEL_SVH

logic [31:0] lcg_state = 32'h78ae;

// Predictor mirror, full word address kept per entry
logic  mdl_valid [BTB_ENTRIES];
addr_t mdl_pc    [BTB_ENTRIES];
logic  mdl_take  [BTB_ENTRIES];
addr_t mdl_tgt   [BTB_ENTRIES];

// Expected groups, oldest first
addr_t      exp_pc;
addr_t      exp_pc_q   [$];
slot_mask_t exp_en_q   [$];
logic       exp_take_q [$];
addr_t      exp_tgt_q  [$];

function automatic int unsigned pick(int unsigned n);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:8] % n;
endfunction

function automatic word_t mem_word(addr_t a);
    return a ^ 32'h5a5a_0000;
endfunction

function automatic group_data_t mem_group(addr_t base);
    group_data_t g;
    for (int i = 0; i < GROUP_WORDS; i++)
        g[i] = mem_word(base + addr_t'(4 * i));
    return g;
endfunction

function automatic void clear_table();
    for (int i = 0; i < BTB_ENTRIES; i++)
        mdl_valid[i] = 1'b0;
endfunction

function automatic void write_entry(addr_t pc, logic take, addr_t tgt);
    int idx;
    idx = (pc >> 2) % BTB_ENTRIES;
    mdl_valid[idx] = 1'b1;
    mdl_pc[idx]    = pc;
    mdl_take[idx]  = take;
    mdl_tgt[idx]   = tgt;
endfunction

// New stream, everything still expected is dropped
function automatic void restart_stream(addr_t pc);
    exp_pc = pc;
    exp_pc_q.delete();
    exp_en_q.delete();
    exp_take_q.delete();
    exp_tgt_q.delete();
endfunction

// One request issued, queue its group and move the PC on
function automatic void predict_group();
    addr_t      base;
    addr_t      slot_pc;
    slot_mask_t en;
    logic       take;
    addr_t      tgt;
    int         idx;
    base = {exp_pc[31:4], 4'b0000};
    en   = '0;
    take = 1'b0;
    tgt  = base + 32'd16;
    for (int s = exp_pc[3:2]; s < GROUP_WORDS && !take; s++) begin
        slot_pc = base + addr_t'(4 * s);
        idx     = (slot_pc >> 2) % BTB_ENTRIES;
        en[s]   = 1'b1;
        if (mdl_valid[idx] && mdl_take[idx] && mdl_pc[idx] == slot_pc) begin
            take = 1'b1;
            tgt  = mdl_tgt[idx];
        end
    end
    exp_pc_q.push_back(exp_pc);
    exp_en_q.push_back(en);
    exp_take_q.push_back(take);
    exp_tgt_q.push_back(tgt);
    exp_pc = tgt;
endfunction

`endif

// ==== testbench/fetch_tb.sv ====
////////////////////////////////////////
// Fetch stage testbench
// Memory and queue handshakes are random
// from a fixed LCG seed; every group is
// checked against the model
////////////////////////////////////////
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();

    localparam addr_t RESET_PC     = 32'h0000_1000;
    localparam int    BTB_ENTRIES  = 16;
    localparam int    MAX_INFLIGHT = 2;

    localparam int N_SEQ       = 32;
    localparam int N_BP        = 120;
    localparam int N_REDIR     = 60;
    localparam int N_PRED      = 100;
    localparam int N_GROUPS    = 1 + N_SEQ + N_BP + 2 + N_REDIR + 4 + N_PRED;
    localparam int CYCLE_LIMIT = 40 * N_GROUPS;

    logic        clk = 1'b0;
    logic        arst_n_i;
    logic        mem_req_valid_o;
    logic        mem_req_ready_i;
    addr_t       mem_req_addr_o;
    logic        mem_rsp_valid_i;
    group_data_t mem_rsp_data_i;
    logic        grp_valid_o;
    logic        grp_ready_i;
    addr_t       grp_pc_o;
    slot_mask_t  grp_enable_o;
    group_data_t grp_inst_o;
    logic        grp_pred_take_o;
    addr_t       grp_pred_target_o;
    logic        redirect_valid_i;
    addr_t       redirect_pc_i;
    logic        bp_update_valid_i;
    addr_t       bp_update_pc_i;
    logic        bp_update_take_i;
    addr_t       bp_update_target_i;

    int unsigned cyc;
    int unsigned errors;
    int unsigned checks;
    int unsigned grp_count;
    int unsigned mem_ready_pct;
    int unsigned grp_ready_pct;
    logic        rand_redirect;
    logic        rand_update;
    logic        redir_req;       // Set by a test and driven on the next edge
    addr_t       redir_pc;
    logic        upd_req;
    addr_t       upd_pc;
    logic        upd_take;
    addr_t       upd_target;
    addr_t       last_pc;
    slot_mask_t  last_en;
    logic        last_take;
    addr_t       last_tgt;
    addr_t       pend_addr [$];   // Memory requests waiting for a response
    int unsigned pend_due  [$];

    `include "fetch_model.svh"

    always #10 clk = ~clk;

    fetch_top #(
        .RESET_PC     (RESET_PC),
        .BTB_ENTRIES  (BTB_ENTRIES),
        .MAX_INFLIGHT (MAX_INFLIGHT)
    ) dut (.*);

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    function automatic void check_value(string name, logic [127:0] got, logic [127:0] exp);
        checks++;
        assert (got === exp)
        else begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endfunction

    task automatic check_group();
        assert (exp_pc_q.size() != 0)
        else begin
            $display("A group was delivered while no fetch was outstanding");
            errors++;
        end
        if (exp_pc_q.size() != 0) begin
            check_value("grp_pc_o", grp_pc_o, exp_pc_q[0]);
            check_value("grp_enable_o", grp_enable_o, exp_en_q[0]);
            check_value("grp_inst_o", grp_inst_o, mem_group({exp_pc_q[0][31:4], 4'b0000}));
            check_value("grp_pred_take_o", grp_pred_take_o, exp_take_q[0]);
            if (exp_take_q[0])
                check_value("grp_pred_target_o", grp_pred_target_o, exp_tgt_q[0]);
            void'(exp_pc_q.pop_front());
            void'(exp_en_q.pop_front());
            void'(exp_take_q.pop_front());
            void'(exp_tgt_q.pop_front());
        end
        last_pc   = grp_pc_o;
        last_en   = grp_enable_o;
        last_take = grp_pred_take_o;
        last_tgt  = grp_pred_target_o;
        grp_count++;
    endtask

    ////////////////////////////////////////
    // Memory responder and input drive
    ////////////////////////////////////////

    task automatic respond();
        if (pend_due.size() != 0 && cyc >= pend_due[0]) begin
            mem_rsp_valid_i <= 1'b1;
            mem_rsp_data_i  <= mem_group(pend_addr.pop_front());
            void'(pend_due.pop_front());
        end else begin
            mem_rsp_valid_i <= 1'b0;
        end
    endtask

    task automatic drive_inputs();
        mem_req_ready_i   <= (pick(100) < mem_ready_pct);
        grp_ready_i       <= (pick(100) < grp_ready_pct);
        redirect_valid_i  <= 1'b0;
        bp_update_valid_i <= 1'b0;
        if (redir_req) begin
            redirect_valid_i <= 1'b1;
            redirect_pc_i    <= redir_pc;
            redir_req = 1'b0;
        end else if (rand_redirect && pick(100) < 2) begin
            redirect_valid_i <= 1'b1;
            redirect_pc_i    <= 32'h1000 + 4 * pick(1024);
        end
        if (upd_req) begin
            bp_update_valid_i  <= 1'b1;
            bp_update_pc_i     <= upd_pc;
            bp_update_take_i   <= upd_take;
            bp_update_target_i <= upd_target;
            upd_req = 1'b0;
        end else if (rand_update && pick(100) < 6) begin
            bp_update_valid_i  <= 1'b1;
            bp_update_pc_i     <= 32'h1000 + 4 * pick(256);    // Overlaps the redirect range
            bp_update_take_i   <= (pick(4) != 0);
            bp_update_target_i <= 32'h1000 + 4 * pick(1024);
        end
    endtask

    always @(posedge clk) begin
        if (!arst_n_i) begin
            check_value("mem_req_valid_o", mem_req_valid_o, 1'b0);
            check_value("grp_valid_o", grp_valid_o, 1'b0);
        end else if (cyc >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with %0d groups delivered", cyc, grp_count);
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            cyc++;
            if (grp_valid_o && grp_ready_i)
                check_group();
            if (redirect_valid_i)
                restart_stream(redirect_pc_i);
            if (mem_req_valid_o && mem_req_ready_i) begin
                check_value("mem_req_addr_o", mem_req_addr_o, {exp_pc[31:4], 4'b0000});
                predict_group();
                pend_addr.push_back(mem_req_addr_o);
                pend_due.push_back(cyc + 1 + pick(4));    // 1 to 4 cycles
            end
            if (bp_update_valid_i)
                write_entry(bp_update_pc_i, bp_update_take_i, bp_update_target_i);
            respond();
            drive_inputs();
        end
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    task automatic wait_groups(int unsigned n);
        int unsigned target;
        target = grp_count + n;
        while (grp_count < target)
            @(negedge clk);
    endtask

    task automatic redirect_to(addr_t pc);
        @(negedge clk);
        redir_pc  = pc;
        redir_req = 1'b1;
        @(negedge clk);    // Driven
        @(negedge clk);    // Taken by the DUT
    endtask

    task automatic update_entry(addr_t pc, logic take, addr_t tgt);
        @(negedge clk);
        upd_pc     = pc;
        upd_take   = take;
        upd_target = tgt;
        upd_req    = 1'b1;
        @(negedge clk);
        @(negedge clk);    // Written, visible from here
    endtask

    task automatic report_test(string name, int unsigned err0);
        $display("%s: %0d groups so far, %0d errors", name, grp_count, errors - err0);
    endtask

    initial begin
        int unsigned err0;
        arst_n_i           = 1'b0;
        mem_req_ready_i    = 1'b0;
        mem_rsp_valid_i    = 1'b0;
        mem_rsp_data_i     = '0;
        grp_ready_i        = 1'b0;
        redirect_valid_i   = 1'b0;
        redirect_pc_i      = '0;
        bp_update_valid_i  = 1'b0;
        bp_update_pc_i     = '0;
        bp_update_take_i   = 1'b0;
        bp_update_target_i = '0;
        cyc           = 0;
        errors        = 0;
        checks        = 0;
        grp_count     = 0;
        mem_ready_pct = 100;
        grp_ready_pct = 100;
        rand_redirect = 1'b0;
        rand_update   = 1'b0;
        redir_req     = 1'b0;
        redir_pc      = '0;
        upd_req       = 1'b0;
        upd_pc        = '0;
        upd_take      = 1'b0;
        upd_target    = '0;
        clear_table();
        restart_stream(RESET_PC);

        err0 = errors;
        repeat (8) @(posedge clk);
        arst_n_i <= 1'b1;
        wait_groups(1);
        check_value("grp_pc_o", last_pc, RESET_PC);
        report_test("reset_start", err0);

        err0 = errors;
        wait_groups(N_SEQ);
        report_test("sequential", err0);

        err0 = errors;
        @(negedge clk);
        mem_ready_pct = 60;
        grp_ready_pct = 50;
        wait_groups(N_BP);
        report_test("backpressure", err0);

        err0 = errors;
        redirect_to(32'h0000_4008);
        wait_groups(1);
        check_value("grp_pc_o", last_pc, 32'h0000_4008);
        check_value("grp_enable_o", last_en, 4'b1100);
        redirect_to(32'h0000_470c);
        wait_groups(1);
        check_value("grp_pc_o", last_pc, 32'h0000_470c);
        check_value("grp_enable_o", last_en, 4'b1000);
        rand_redirect = 1'b1;
        wait_groups(N_REDIR);
        rand_redirect = 1'b0;
        report_test("redirect", err0);

        // Taken branch in slot 2 with the stream entering at slot 1
        err0 = errors;
        update_entry(32'h0000_5008, 1'b1, 32'h0000_6004);
        redirect_to(32'h0000_5004);
        wait_groups(1);
        check_value("grp_enable_o", last_en, 4'b0110);
        check_value("grp_pred_take_o", last_take, 1'b1);
        check_value("grp_pred_target_o", last_tgt, 32'h0000_6004);
        wait_groups(1);
        check_value("grp_pc_o", last_pc, 32'h0000_6004);
        update_entry(32'h0000_5008, 1'b0, 32'h0000_6004);
        redirect_to(32'h0000_5004);
        wait_groups(1);
        check_value("grp_enable_o", last_en, 4'b1110);
        check_value("grp_pred_take_o", last_take, 1'b0);
        wait_groups(1);
        check_value("grp_pc_o", last_pc, 32'h0000_5010);
        rand_update   = 1'b1;
        rand_redirect = 1'b1;
        wait_groups(N_PRED);
        report_test("prediction", err0);

        $display("checks %0d, errors %0d, groups %0d", checks, errors, grp_count);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+testbench
logic/fetch_pkg.sv
logic/bpred_pkg.sv
logic/fetch_ifs.sv
logic/pc_register.sv
logic/branch_target_buffer.sv
logic/fetch_trace.sv
logic/fetch_top.sv
testbench/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_stage

sources:
  - files:
      - logic/fetch_pkg.sv
      - logic/bpred_pkg.sv
      - logic/fetch_ifs.sv
      - logic/pc_register.sv
      - logic/branch_target_buffer.sv
      - logic/fetch_trace.sv
      - logic/fetch_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/fetch_tb.sv
